//--- logic/cpuPkg.sv
package cpuPkg;

    localparam logic [31:0] resetVector = 32'h0000_0010; // first fetch
    localparam logic [3:0]  pcIdx = 4'd15;               // register 15 aliases the pc
    localparam int          packBits = 12;               // low field width of pack

    // ALU opcodes, encoded as in instruction bits 15..12
    typedef enum logic [3:0] {
        opOr     = 4'h0,
        opAnd    = 4'h1,
        opXor    = 4'h2,
        opAsr    = 4'h3,
        opAdd    = 4'h4,
        opMul    = 4'h5,
        opEq     = 4'h6,
        opLt     = 4'h7,
        opOrNot  = 4'h8,
        opAndNot = 4'h9,
        opPack   = 4'ha,
        opLsr    = 4'hb,
        opSub    = 4'hc,
        opShl    = 4'hd,
        opBit    = 4'he,
        opGe     = 4'hf
    } aluOp;

    typedef enum logic [1:0] {
        xyImm   = 2'b00, // a=x b=y c=imm
        xImmY   = 2'b01, // a=x b=imm c=y
        immXY   = 2'b10, // a=imm b=x c=y
        wideImm = 2'b11  // a=0 b=x c=imm20
    } insnKind;

    typedef enum logic [2:0] {
        execStart  = 3'd0,
        execWait   = 3'd1,
        addrSetup  = 3'd2,
        dataAccess = 3'd3,
        writeBack  = 3'd4,
        fetchReq   = 3'd5,
        fetchLatch = 3'd6
    } seqState;

    typedef struct packed {
        insnKind     kind;
        aluOp        op;
        logic [3:0]  z;
        logic [3:0]  x;
        logic [3:0]  y;
        logic [31:0] imm;       // already sign-extended
        logic        storing;
        logic        loading;
        logic        derefRhs;  // memory address is the result
        logic        branching;
    } decodedInsn;

    typedef struct packed {
        logic [31:0] a;
        logic [31:0] b;
        logic [31:0] c;
    } operandSet;

endpackage

//--- logic/regFile.sv
`timescale 1ns/1ps

module regFile (
    input  logic        clk,
    input  logic        writeEn_i,
    input  logic [3:0]  writeIdx_i,
    input  logic [31:0] writeData_i,
    input  logic [3:0]  readIdxX_i,
    input  logic [3:0]  readIdxY_i,
    input  logic [3:0]  readIdxZ_i,
    input  logic [31:0] progCount_i,
    output logic [31:0] valX_o,
    output logic [31:0] valY_o,
    output logic [31:0] valZ_o
);

    logic [31:0] regs [0:14] = '{default: 32'd0}; // entry 0 is never written

    function automatic logic [31:0] readPort(input logic [3:0] idx);
        if (idx == 4'd15) begin
            return progCount_i; // pc alias
        end
        return regs[idx];
    endfunction

    assign valX_o = readPort(readIdxX_i);
    assign valY_o = readPort(readIdxY_i);
    assign valZ_o = readPort(readIdxZ_i);

    always_ff @(posedge clk) begin
        if (writeEn_i && writeIdx_i != 4'd0 && writeIdx_i != 4'd15) begin
            regs[writeIdx_i] <= writeData_i;
        end
    end

endmodule

//--- logic/insnDecoder.sv
`timescale 1ns/1ps

module insnDecoder (
    input  logic [31:0]        insn_i,
    output cpuPkg::decodedInsn decoded_o
);

    cpuPkg::insnKind kind;
    logic [1:0]      mode;
    logic [3:0]      zIdx;

    assign kind = cpuPkg::insnKind'(insn_i[31:30]);
    assign mode = insn_i[29:28];
    assign zIdx = insn_i[27:24];

    always_comb begin
        decoded_o.kind = kind;
        decoded_o.z    = zIdx;
        decoded_o.x    = insn_i[23:20];

        if (kind == cpuPkg::wideImm) begin
            decoded_o.y   = 4'd0;
            decoded_o.op  = cpuPkg::opOr;
            decoded_o.imm = {{12{insn_i[19]}}, insn_i[19:0]}; // 20 bit immediate
        end else begin
            decoded_o.y   = insn_i[19:16];
            decoded_o.op  = cpuPkg::aluOp'(insn_i[15:12]);
            decoded_o.imm = {{20{insn_i[11]}}, insn_i[11:0]};
        end

        // mode 01 and 10 store, 11 loads
        decoded_o.storing   = ^mode;
        decoded_o.loading   = &mode;
        decoded_o.derefRhs  = mode[0];
        decoded_o.branching = (zIdx == cpuPkg::pcIdx) && !(^mode);
    end

endmodule

//--- logic/operandRouter.sv
`timescale 1ns/1ps

module operandRouter (
    input  cpuPkg::insnKind   kind_i,
    input  logic [31:0]       valX_i,
    input  logic [31:0]       valY_i,
    input  logic [31:0]       imm_i,
    output cpuPkg::operandSet operands_o
);

    always_comb begin
        case (kind_i)
            cpuPkg::xyImm: begin
                operands_o = '{a: valX_i, b: valY_i, c: imm_i};
            end
            cpuPkg::xImmY: begin
                operands_o = '{a: valX_i, b: imm_i, c: valY_i};
            end
            cpuPkg::immXY: begin
                operands_o = '{a: imm_i, b: valX_i, c: valY_i};
            end
            default: begin
                operands_o = '{a: 32'd0, b: valX_i, c: imm_i}; // wide immediate
            end
        endcase
    end

endmodule

//--- logic/execUnit.sv
`timescale 1ns/1ps

module execUnit (
    input  logic              clk,
    input  logic              reset,
    input  logic              start_i,
    input  cpuPkg::aluOp      op_i,
    input  cpuPkg::operandSet operands_i,
    output logic              done_o,
    output logic [31:0]       result_o
);

    cpuPkg::aluOp       opReg;
    logic signed [31:0] aReg;
    logic signed [31:0] bReg;
    logic [31:0]        cReg;
    logic [31:0]        aluOut;
    logic [31:0]        opOut;  // A op B
    logic [31:0]        sumReg; // plus C
    logic [31:0]        logicShift;
    logic               v1;
    logic               v2;
    logic               v3;

    assign logicShift = aReg >> bReg;

    always_comb begin
        case (opReg)
            cpuPkg::opOr:     aluOut = aReg | bReg;
            cpuPkg::opAnd:    aluOut = aReg & bReg;
            cpuPkg::opXor:    aluOut = aReg ^ bReg;
            cpuPkg::opAsr:    aluOut = aReg >>> bReg;
            cpuPkg::opAdd:    aluOut = aReg + bReg;
            cpuPkg::opMul:    aluOut = aReg * bReg;
            cpuPkg::opEq:     aluOut = {32{aReg == bReg}};
            cpuPkg::opLt:     aluOut = {32{aReg < bReg}};
            cpuPkg::opOrNot:  aluOut = aReg | ~bReg;
            cpuPkg::opAndNot: aluOut = aReg & ~bReg;
            cpuPkg::opPack: begin
                aluOut = {aReg[31-cpuPkg::packBits:0], bReg[cpuPkg::packBits-1:0]};
            end
            cpuPkg::opLsr:    aluOut = logicShift;
            cpuPkg::opSub:    aluOut = aReg - bReg;
            cpuPkg::opShl:    aluOut = aReg << bReg;
            cpuPkg::opBit:    aluOut = {32{logicShift[0]}}; // selected bit of A
            default:          aluOut = {32{aReg >= bReg}};  // opGe
        endcase
    end

    // valid bit walks alongside the data
    always_ff @(posedge clk) begin
        if (reset) begin
            {v1, v2, v3, done_o} <= 4'b0000;
        end else begin
            {v1, v2, v3, done_o} <= {start_i, v1, v2, v3};
        end
    end

    always_ff @(posedge clk) begin
        if (start_i) begin
            opReg <= op_i;
            aReg  <= operands_i.a;
            bReg  <= operands_i.b;
            cReg  <= operands_i.c;
        end
        if (v1) opOut <= aluOut;
        if (v2) sumReg <= opOut + cReg;
        if (v3) result_o <= sumReg; // held until next start
    end

endmodule

//--- logic/coreSequencer.sv
`timescale 1ns/1ps

module coreSequencer (
    input  logic               clk,
    input  logic               reset,
    input  cpuPkg::decodedInsn decoded_i,
    input  logic [31:0]        result_i,
    input  logic               execDone_i,
    input  logic [31:0]        valZ_i,
    output logic [31:0]        adr_o,
    input  logic [31:0]        dat_i,
    output logic [31:0]        dat_o,
    output logic               we_o,
    output logic               stb_o,
    input  logic               ack_i,
    input  logic               err_i,
    input  logic               rty_i,
    output logic               cyc_o,
    output logic               halt_o,
    output logic [31:0]        insn_o,
    output logic [31:0]        progCount_o,
    output logic               execStart_o,
    output logic               regWrite_o,
    output logic [31:0]        regWriteData_o
);

    cpuPkg::seqState state;
    logic [31:0]     insnReg;
    logic [31:0]     resultReg;
    logic [31:0]     loadData;
    logic [31:0]     nextPc;
    logic [31:0]     nextAdr;
    logic            memAccess;
    logic            halted;

    assign memAccess = decoded_i.storing | decoded_i.loading;
    assign halted    = err_i | rty_i;
    assign halt_o    = halted;

    // one strobe for both fetch and data cycles
    assign stb_o = (state == cpuPkg::fetchReq) || (state == cpuPkg::dataAccess);
    assign cyc_o = stb_o;
    assign we_o  = (state == cpuPkg::dataAccess) && decoded_i.storing;
    assign dat_o = decoded_i.derefRhs ? valZ_i : resultReg;

    assign execStart_o    = (state == cpuPkg::execStart) && !halted;
    assign regWrite_o     = (state == cpuPkg::writeBack) && !decoded_i.storing;
    assign regWriteData_o = decoded_i.derefRhs ? loadData : resultReg;

    // a write to register 15 becomes the next fetch address
    assign nextAdr = decoded_i.branching ? regWriteData_o : nextPc;

    assign insn_o      = insnReg;
    assign progCount_o = nextPc;

    always_ff @(posedge clk) begin
        if (reset) begin
            state <= cpuPkg::fetchReq;
            adr_o <= cpuPkg::resetVector;
        end else begin
            case (state)
                cpuPkg::execStart: begin
                    if (!halted) state <= cpuPkg::execWait; // frozen on err or rty
                end
                cpuPkg::execWait: begin
                    if (execDone_i) state <= cpuPkg::addrSetup;
                end
                cpuPkg::addrSetup: begin
                    adr_o <= decoded_i.derefRhs ? resultReg : valZ_i;
                    state <= memAccess ? cpuPkg::dataAccess : cpuPkg::writeBack;
                end
                cpuPkg::dataAccess: begin
                    if (ack_i) state <= cpuPkg::writeBack;
                end
                cpuPkg::writeBack: begin
                    adr_o <= nextAdr;
                    state <= cpuPkg::fetchReq;
                end
                cpuPkg::fetchReq: begin
                    if (ack_i) state <= cpuPkg::fetchLatch;
                end
                cpuPkg::fetchLatch: begin
                    state <= cpuPkg::execStart;
                end
                default: begin
                    state <= cpuPkg::fetchReq;
                end
            endcase
        end
    end

    // data is sampled on the ack edge
    always_ff @(posedge clk) begin
        if (state == cpuPkg::execWait && execDone_i) begin
            resultReg <= result_i;
        end
        if (state == cpuPkg::dataAccess && ack_i) begin
            loadData <= dat_i;
        end
        if (state == cpuPkg::fetchReq && ack_i) begin
            insnReg <= dat_i;
        end
        if (state == cpuPkg::fetchLatch) begin
            nextPc <= adr_o + 32'd1; // fetch address still on adr_o
        end
    end

endmodule

//--- logic/cpuCore.sv
`timescale 1ns/1ps

module cpuCore (
    input  logic        clk,
    input  logic        reset,
    output logic [31:0] adr_o,
    input  logic [31:0] dat_i,
    output logic [31:0] dat_o,
    output logic        we_o,
    output logic        stb_o,
    input  logic        ack_i,
    input  logic        err_i,
    input  logic        rty_i,
    output logic        cyc_o,
    output logic        halt_o
);

    cpuPkg::decodedInsn decoded;
    cpuPkg::operandSet  operands;
    logic [31:0]        insn;
    logic [31:0]        progCount;
    logic [31:0]        valX;
    logic [31:0]        valY;
    logic [31:0]        valZ;
    logic [31:0]        result;
    logic [31:0]        regWriteData;
    logic               execStart;
    logic               execDone;
    logic               regWrite;

    coreSequencer i_coreSequencer (
        .clk, .reset, .decoded_i(decoded), .result_i(result), .execDone_i(execDone),
        .valZ_i(valZ), .adr_o, .dat_i, .dat_o, .we_o, .stb_o, .ack_i, .err_i, .rty_i,
        .cyc_o, .halt_o, .insn_o(insn), .progCount_o(progCount),
        .execStart_o(execStart), .regWrite_o(regWrite), .regWriteData_o(regWriteData)
    );

    insnDecoder i_insnDecoder (.insn_i(insn), .decoded_o(decoded));

    operandRouter i_operandRouter (
        .kind_i(decoded.kind), .valX_i(valX), .valY_i(valY), .imm_i(decoded.imm),
        .operands_o(operands)
    );

    execUnit i_execUnit (
        .clk, .reset, .start_i(execStart), .op_i(decoded.op), .operands_i(operands),
        .done_o(execDone), .result_o(result)
    );

    regFile i_regFile (
        .clk, .writeEn_i(regWrite), .writeIdx_i(decoded.z), .writeData_i(regWriteData),
        .readIdxX_i(decoded.x), .readIdxY_i(decoded.y), .readIdxZ_i(decoded.z),
        .progCount_i(progCount), .valX_o(valX), .valY_o(valY), .valZ_o(valZ)
    );

endmodule

//--- testbench/busMemory.sv
`timescale 1ns/1ps

module busMemory (
    input  logic        clk,
    input  logic        reset,
    input  logic [31:0] adr_i,
    input  logic [31:0] dat_i,
    output logic [31:0] dat_o,
    input  logic        we_i,
    input  logic        stb_i,
    output logic        ack_o = 1'b0,
    output logic        err_o,
    output logic        rty_o,
    input  logic [1:0]  ackDelay_i,
    input  logic        errInject_i,
    output logic        logStrobe_o = 1'b0,
    output logic [31:0] logAdr_o = 32'd0,
    output logic [31:0] logData_o = 32'd0
);

    localparam int depth = 64;

    logic [31:0] mem [depth];
    logic [5:0]  idx;
    logic [1:0]  waitCount = 2'd0;
    logic        writeHit;

    assign idx      = adr_i[5:0]; // word address, upper bits alias
    assign dat_o    = mem[idx];
    assign err_o    = errInject_i;
    assign rty_o    = 1'b0;
    assign writeHit = stb_i && we_i && ack_o;

    initial begin
        for (int i = 0; i < depth; i++) begin
            mem[i] = 32'hc0de_0000 | 32'(i); // tagged with its own address
        end
    end

    task automatic loadWord(input logic [31:0] adr, input logic [31:0] data);
        mem[adr[5:0]] = data;
    endtask

    // ack comes 1 + ackDelay_i cycles into the strobe
    always @(posedge clk) begin
        if (reset) begin
            ack_o     <= 1'b0;
            waitCount <= 2'd0;
        end else if (stb_i && !ack_o) begin
            if (waitCount >= ackDelay_i) begin
                ack_o     <= 1'b1;
                waitCount <= 2'd0;
            end else begin
                waitCount <= waitCount + 2'd1;
            end
        end else begin
            ack_o <= 1'b0;
        end
    end

    always @(posedge clk) begin
        if (writeHit) begin
            mem[idx] = dat_i;
        end
    end

    // one log pulse per acknowledged write
    always @(posedge clk) begin
        logStrobe_o <= !reset && writeHit;
        if (writeHit) begin
            logAdr_o  <= adr_i;
            logData_o <= dat_i;
        end
    end

endmodule

//--- testbench/cpuCore_chk.sv
`timescale 1ns/1ps

module cpuCoreChk (
    input logic        clk,
    input logic        reset,
    input logic [31:0] adr_i,
    input logic [31:0] wrData_i,
    input logic        we_i,
    input logic        stb_i,
    input logic        cyc_i,
    input logic        ack_i
);

    cycMatchesStb: assert property (@(posedge clk) disable iff (reset) stb_i == cyc_i)
        else $error("cyc_o differs from stb_o");

    writeNeedsStb: assert property (@(posedge clk) disable iff (reset) we_i |-> stb_i)
        else $error("we_o is high without stb_o");

    // address and data held until the ack edge
    heldUntilAck: assert property (@(posedge clk) disable iff (reset)
        stb_i && !ack_i |=> $stable(adr_i) && $stable(wrData_i))
        else $error("bus address or data changed before ack_i");

    firstFetch: assert property (@(posedge clk)
        $fell(reset) |-> stb_i && adr_i == cpuPkg::resetVector)
        else $error("first fetch after reset is not at the reset vector");

endmodule

bind cpuCore cpuCoreChk i_cpuCoreChk (
    .clk, .reset, .adr_i(adr_o), .wrData_i(dat_o), .we_i(we_o), .stb_i(stb_o),
    .cyc_i(cyc_o), .ack_i
);

//--- testbench/cpuCoreTb.sv
`timescale 1ns/1ps

module cpuCoreTb;

    typedef struct packed {
        logic [31:0] adr;
        logic [31:0] data;
    } busWrite;

    localparam int progLen    = 30;
    localparam int writeCount = 21;
    localparam int holdAfter  = 17; // err_i raised once this write is seen
    localparam int holdCycles = 40;
    localparam int cycleLimit = progLen * 30 + holdCycles;
    localparam logic [31:0] dataAdr  = 32'h0000_0038;
    localparam logic [31:0] dataWord = 32'h1234_5678;

    localparam logic [1:0] toReg    = 2'b00;
    localparam logic [1:0] storeZ   = 2'b01;
    localparam logic [1:0] storeRes = 2'b10;
    localparam logic [1:0] loadZ    = 2'b11;

    logic        clk = 1'b0;
    logic        reset;
    logic [31:0] adr;
    logic [31:0] rdData;
    logic [31:0] coreData;
    logic        we;
    logic        stb;
    logic        cyc;
    logic        ack;
    logic        err;
    logic        rty;
    logic        halt;
    logic [1:0]  ackDelay;
    logic        errInject;
    logic        logStrobe;
    logic [31:0] logAdr;
    logic [31:0] logData;
    int          cycleCount = 0;

    logic [31:0] progWords [progLen];
    busWrite     expWrites [writeCount];

    cpuCore i_cpuCore (
        .clk, .reset, .adr_o(adr), .dat_i(rdData), .dat_o(coreData), .we_o(we), .stb_o(stb),
        .ack_i(ack), .err_i(err), .rty_i(rty), .cyc_o(cyc), .halt_o(halt)
    );

    busMemory i_busMemory (
        .clk, .reset, .adr_i(adr), .dat_i(coreData), .dat_o(rdData), .we_i(we), .stb_i(stb),
        .ack_o(ack), .err_o(err), .rty_o(rty), .ackDelay_i(ackDelay), .errInject_i(errInject),
        .logStrobe_o(logStrobe), .logAdr_o(logAdr), .logData_o(logData)
    );

    initial begin
        forever #5 clk = ~clk;
    end

    // zxy packs the three register indices
    function automatic logic [31:0] insnWord(input cpuPkg::insnKind kind, input logic [1:0] mode,
                                             input logic [11:0] zxy, input cpuPkg::aluOp op,
                                             input logic [11:0] imm);
        return {kind, mode, zxy, op, imm};
    endfunction

    function automatic logic [31:0] wideWord(input logic [1:0] mode, input logic [7:0] zx,
                                             input logic [19:0] imm);
        return {cpuPkg::wideImm, mode, zx, imm};
    endfunction

    task automatic compareValue(input string name, input logic [31:0] actual,
                                input logic [31:0] expected);
        if (actual !== expected) begin
            $display("error %s: got 0x%08h, expected 0x%08h", name, actual, expected);
            $display("Checks failed");
            $fatal(1, "mismatch on %s", name);
        end
    endtask

    task automatic buildTables();
        progWords[0]  = wideWord(toReg, 8'h10, 20'h00030);
        progWords[1]  = wideWord(toReg, 8'h20, 20'h00005);
        progWords[2]  = wideWord(toReg, 8'h30, 20'hffffd);  // r3 = -3
        progWords[3]  = insnWord(cpuPkg::xyImm, storeRes, 12'h123, cpuPkg::opAdd, 12'h100);
        progWords[4]  = insnWord(cpuPkg::xImmY, storeRes, 12'h123, cpuPkg::opMul, 12'h007);
        progWords[5]  = insnWord(cpuPkg::immXY, storeRes, 12'h120, cpuPkg::opSub, 12'h010);
        progWords[6]  = insnWord(cpuPkg::xyImm, storeRes, 12'h132, cpuPkg::opAsr, 12'h000);
        progWords[7]  = insnWord(cpuPkg::xyImm, storeRes, 12'h132, cpuPkg::opLsr, 12'h000);
        progWords[8]  = insnWord(cpuPkg::xyImm, storeRes, 12'h132, cpuPkg::opLt, 12'h002);
        progWords[9]  = insnWord(cpuPkg::xyImm, storeRes, 12'h123, cpuPkg::opGe, 12'h010);
        progWords[10] = insnWord(cpuPkg::xImmY, storeRes, 12'h120, cpuPkg::opPack, 12'habc);
        progWords[11] = insnWord(cpuPkg::immXY, storeRes, 12'h123, cpuPkg::opShl, 12'h003);
        progWords[12] = insnWord(cpuPkg::xyImm, storeRes, 12'h123, cpuPkg::opXor, 12'h000);
        progWords[13] = insnWord(cpuPkg::xyImm, storeRes, 12'h123, cpuPkg::opOrNot, 12'h000);
        progWords[14] = insnWord(cpuPkg::xImmY, storeRes, 12'h122, cpuPkg::opBit, 12'h002);
        progWords[15] = insnWord(cpuPkg::xyImm, storeRes, 12'h122, cpuPkg::opEq, 12'h009);
        progWords[16] = insnWord(cpuPkg::xyImm, storeRes, 12'h123, cpuPkg::opAnd, 12'h020);
        progWords[17] = insnWord(cpuPkg::xImmY, storeRes, 12'h120, cpuPkg::opAndNot, 12'h00c);
        progWords[18] = insnWord(cpuPkg::xyImm, storeRes, 12'h123, cpuPkg::opOr, 12'h010);
        progWords[19] = insnWord(cpuPkg::xyImm, storeZ, 12'h210, cpuPkg::opAdd, 12'h001);
        progWords[20] = insnWord(cpuPkg::xyImm, loadZ, 12'h410, cpuPkg::opOr, 12'h008);
        progWords[21] = insnWord(cpuPkg::xyImm, storeZ, 12'h410, cpuPkg::opAdd, 12'h002);
        progWords[22] = wideWord(toReg, 8'h00, 20'h00777);  // r0 must ignore this
        progWords[23] = insnWord(cpuPkg::xyImm, storeRes, 12'h100, cpuPkg::opAdd, 12'h03c);
        progWords[24] = wideWord(toReg, 8'hf0, 20'h0002b);  // jump over two words
        progWords[25] = insnWord(cpuPkg::xyImm, storeRes, 12'h100, cpuPkg::opAdd, 12'hbad);
        progWords[26] = insnWord(cpuPkg::xyImm, storeRes, 12'h100, cpuPkg::opAdd, 12'hbad);
        progWords[27] = insnWord(cpuPkg::xyImm, storeRes, 12'h1f0, cpuPkg::opAdd, 12'h000);
        progWords[28] = wideWord(storeRes, 8'h12, 20'hfffff);
        progWords[29] = wideWord(toReg, 8'hf0, 20'h0002d);  // spin here

        expWrites[0]  = '{32'h30, 32'h0000_0102};
        expWrites[1]  = '{32'h30, 32'h0000_0020};
        expWrites[2]  = '{32'h30, 32'h0000_000b};
        expWrites[3]  = '{32'h30, 32'hffff_ffff};
        expWrites[4]  = '{32'h30, 32'h07ff_ffff};
        expWrites[5]  = '{32'h30, 32'h0000_0001};
        expWrites[6]  = '{32'h30, 32'h0000_000f};
        expWrites[7]  = '{32'h30, 32'h0000_5abc};
        expWrites[8]  = '{32'h30, 32'h0000_005d};
        expWrites[9]  = '{32'h30, 32'hffff_fff8};
        expWrites[10] = '{32'h30, 32'h0000_0007};
        expWrites[11] = '{32'h30, 32'h0000_0004};
        expWrites[12] = '{32'h30, 32'h0000_0008};
        expWrites[13] = '{32'h30, 32'h0000_0025};
        expWrites[14] = '{32'h30, 32'h0000_0001};
        expWrites[15] = '{32'h30, 32'h0000_000d};
        expWrites[16] = '{32'h31, 32'h0000_0005};
        expWrites[17] = '{32'h32, dataWord};
        expWrites[18] = '{32'h30, 32'h0000_003c};
        expWrites[19] = '{32'h30, 32'h0000_002c};  // pc + 1 after the branch
        expWrites[20] = '{32'h30, 32'h0000_0004};
    endtask

    task automatic waitForWrite();
        do begin
            @(posedge clk);
            #1;
        end while (!logStrobe);
    endtask

    task automatic holdWithError();
        errInject = 1'b1;
        repeat (holdCycles) begin
            @(posedge clk);
            #1;
            compareValue("halt_o", 32'(halt), 32'd1);
            compareValue("write strobe while halted", 32'(logStrobe), 32'd0);
        end
        errInject = 1'b0;
        @(posedge clk);
        #1;
        compareValue("halt_o", 32'(halt), 32'd0);
    endtask

    // new ack delay every cycle
    initial begin
        void'($urandom(81469));
        ackDelay = 2'd0;
        forever begin
            @(posedge clk);
            #1;
            ackDelay = 2'($urandom % 4);
        end
    end

    always @(posedge clk) begin
        cycleCount <= cycleCount + 1;
        if (cycleCount >= cycleLimit) begin
            $display("timeout: expected bus writes did not arrive within %0d cycles", cycleLimit);
            $display("Checks failed");
            $fatal(1, "simulation timed out");
        end
    end

    initial begin
        reset     = 1'b1;
        errInject = 1'b0;
        buildTables();
        @(posedge clk);
        #1;
        for (int i = 0; i < progLen; i++) begin
            i_busMemory.loadWord(cpuPkg::resetVector + 32'(i), progWords[i]);
        end
        i_busMemory.loadWord(dataAdr, dataWord);
        repeat (7) @(posedge clk);
        #1;
        reset = 1'b0;
        compareValue("stb_o", 32'(stb), 32'd1);
        compareValue("cyc_o", 32'(cyc), 32'd1);
        compareValue("adr_o", adr, cpuPkg::resetVector);

        for (int i = 0; i < writeCount; i++) begin
            waitForWrite();
            compareValue("adr_o", logAdr, expWrites[i].adr);
            compareValue("dat_o", logData, expWrites[i].data);
            if (i == holdAfter) begin
                holdWithError();
            end
        end

        $display("All checks passed");
        $finish;
    end

endmodule

//--- build.f
logic/cpuPkg.sv
logic/regFile.sv
logic/insnDecoder.sv
logic/operandRouter.sv
logic/execUnit.sv
logic/coreSequencer.sv
logic/cpuCore.sv
testbench/busMemory.sv
testbench/cpuCore_chk.sv
testbench/cpuCoreTb.sv

//--- Makefile
TOOL     = verilator
FLAGS    = --binary --timing --assert -Wno-fatal
TOP      = cpuCoreTb
FILELIST = build.f
OBJDIR   = obj_dir
LOG      = sim.log
PASS     = All checks passed

.PHONY: all compile run clean

all: run

compile:
	$(TOOL) $(FLAGS) --top-module $(TOP) --Mdir $(OBJDIR) -f $(FILELIST)

run: compile
	-./$(OBJDIR)/V$(TOP) > $(LOG) 2>&1
	cat $(LOG)
	grep -q "$(PASS)" $(LOG)

clean:
	rm -rf $(OBJDIR) $(LOG)
